// ==== flist.f ====
verilog/axis_pkg.sv
verilog/fabric_ctrl_pkg.sv
verilog/fabric_if.sv
verilog/cmd_router.sv
verilog/packet_generator.sv
verilog/packet_arbiter.sv
verilog/stream_fabric_top.sv
verification/stream_checker.sv
verification/stream_fabric_tb.sv

// ==== verification/stream_fabric_tb.sv ====
module stream_fabric_tb import axis_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_WIDTH   = DEFAULT_DATA_WIDTH;
  localparam int NUM_CHANNELS = DEFAULT_NUM_CHANNELS;
  localparam int START_COUNT  = DEFAULT_START_COUNT;
  localparam int NUM_ENTRIES  = 14;

  typedef struct {
    chan_t                 channel;
    int                    words;
    logic [DATA_WIDTH-1:0] base;
    logic                  random_ready; // xorshift tready from this entry on
    logic                  wait_idle;    // drain all packets before the next entry
  } cmd_entry_t;

  logic                    M_AXIS_ACLK;
  logic                    M_AXIS_ARESETN;
  logic                    cmd_valid;
  logic                    cmd_ready;
  chan_t                   cmd_channel;
  len_t                    cmd_length;
  logic [DATA_WIDTH-1:0]   cmd_base;
  logic                    tvalid;
  logic                    tready;
  logic [DATA_WIDTH-1:0]   tdata;
  logic [DATA_WIDTH/8-1:0] tstrb;
  logic                    tlast;
  chan_t                   tdest;

  cmd_entry_t  cmd_table [NUM_ENTRIES];
  logic [31:0] rng = 32'd70243;
  logic        ready_random;
  logic        cmd_fire;
  int          cycle_count;
  int          cycle_limit;
  int          error_count;
  int          packet_count;
  int          pending_count;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fill_table();
    cmd_table[0]  = '{2'd0, 1,   32'hFFFF_FFFF, 1'b0, 1'b1}; // single word wraps to zero
    cmd_table[1]  = '{2'd0, 256, 32'h0000_1000, 1'b0, 1'b1};
    cmd_table[2]  = '{2'd1, 12,  32'h1000_0000, 1'b1, 1'b0};
    cmd_table[3]  = '{2'd2, 9,   32'h2000_0000, 1'b1, 1'b0};
    cmd_table[4]  = '{2'd1, 5,   32'h1100_0000, 1'b1, 1'b0}; // channel 1 still busy
    cmd_table[5]  = '{2'd3, 17,  32'h3000_0000, 1'b1, 1'b1};
    cmd_table[6]  = '{2'd2, 6,   32'h4000_0000, 1'b0, 1'b0};
    cmd_table[7]  = '{2'd0, 3,   32'h5000_0000, 1'b0, 1'b0};
    cmd_table[8]  = '{2'd3, 4,   32'h6000_0000, 1'b0, 1'b0};
    cmd_table[9]  = '{2'd1, 5,   32'h7000_0000, 1'b0, 1'b0};
    cmd_table[10] = '{2'd0, 2,   32'h8000_0000, 1'b0, 1'b0};
    cmd_table[11] = '{2'd2, 8,   32'hFFFF_FFFA, 1'b1, 1'b0};
    cmd_table[12] = '{2'd1, 3,   32'hA000_0000, 1'b1, 1'b0};
    cmd_table[13] = '{2'd3, 64,  32'hB000_0000, 1'b1, 1'b1};
  endtask

  function automatic int timeout_cycles();
    int total;
    total = 200;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (cmd_table[i].random_ready) total += 4 * (cmd_table[i].words + START_COUNT + 4);
      else total += cmd_table[i].words + START_COUNT + 4;
    end
    return total;
  endfunction

  initial M_AXIS_ACLK = 1'b0;
  always #4 M_AXIS_ACLK = ~M_AXIS_ACLK;

  always @(posedge M_AXIS_ACLK) cmd_fire <= cmd_valid && cmd_ready;

  always @(negedge M_AXIS_ACLK) begin
    if (ready_random) begin
      tready = rng[0];
      rng    = xorshift32(rng);
    end else begin
      tready = 1'b1;
    end
  end

  always @(posedge M_AXIS_ACLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run timed out after %0d cycles with %0d packets still missing",
               cycle_count, NUM_ENTRIES - packet_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    M_AXIS_ARESETN = 1'b0;
    cmd_valid      = 1'b0;
    cmd_channel    = '0;
    cmd_length     = '0;
    cmd_base       = '0;
    tready         = 1'b0;
    ready_random   = 1'b0;
    cycle_count    = 0;
    fill_table();
    cycle_limit = timeout_cycles();
    repeat (16) @(negedge M_AXIS_ACLK);
    M_AXIS_ARESETN = 1'b1;
    @(negedge M_AXIS_ACLK);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      ready_random <= cmd_table[i].random_ready;
      cmd_valid   = 1'b1;
      cmd_channel = cmd_table[i].channel;
      cmd_length  = len_t'(cmd_table[i].words - 1);
      cmd_base    = cmd_table[i].base;
      do @(negedge M_AXIS_ACLK); while (!cmd_fire); // held until the router takes it
      if (cmd_table[i].wait_idle) begin
        cmd_valid = 1'b0;
        while (pending_count != 0) @(negedge M_AXIS_ACLK);
      end
    end
    cmd_valid = 1'b0;
    while (pending_count != 0) @(negedge M_AXIS_ACLK);
    repeat (START_COUNT + 4) @(negedge M_AXIS_ACLK); // catch stray trailing words
    $display("packets %0d of %0d, errors %0d, pending %0d",
             packet_count, NUM_ENTRIES, error_count, pending_count);
    if (error_count == 0 && packet_count == NUM_ENTRIES) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  stream_fabric_top #(
    .DATA_WIDTH   (DATA_WIDTH),
    .NUM_CHANNELS (NUM_CHANNELS),
    .START_COUNT  (START_COUNT)
  ) stream_fabric_top_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_channel    (cmd_channel),
    .cmd_length     (cmd_length),
    .cmd_base       (cmd_base),
    .tvalid         (tvalid),
    .tready         (tready),
    .tdata          (tdata),
    .tstrb          (tstrb),
    .tlast          (tlast),
    .tdest          (tdest)
  );

  stream_checker #(
    .DATA_WIDTH   (DATA_WIDTH),
    .NUM_CHANNELS (NUM_CHANNELS),
    .START_COUNT  (START_COUNT)
  ) stream_checker_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_channel    (cmd_channel),
    .cmd_length     (cmd_length),
    .cmd_base       (cmd_base),
    .tvalid         (tvalid),
    .tready         (tready),
    .tdata          (tdata),
    .tstrb          (tstrb),
    .tlast          (tlast),
    .tdest          (tdest),
    .error_count    (error_count),
    .packet_count   (packet_count),
    .pending_count  (pending_count)
  );

endmodule

// ==== verification/stream_checker.sv ====
module stream_checker import axis_pkg::*; #(
  parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH,
  parameter int NUM_CHANNELS = DEFAULT_NUM_CHANNELS,
  parameter int START_COUNT  = DEFAULT_START_COUNT
) (
  input  logic                    M_AXIS_ACLK,
  input  logic                    M_AXIS_ARESETN,
  input  logic                    cmd_valid,
  input  logic                    cmd_ready,
  input  chan_t                   cmd_channel,
  input  len_t                    cmd_length,
  input  logic [DATA_WIDTH-1:0]   cmd_base,
  input  logic                    tvalid,
  input  logic                    tready,
  input  logic [DATA_WIDTH-1:0]   tdata,
  input  logic [DATA_WIDTH/8-1:0] tstrb,
  input  logic                    tlast,
  input  chan_t                   tdest,
  output int                      error_count,
  output int                      packet_count,
  output int                      pending_count
);

  timeunit 1ns;
  timeprecision 100ps;

  // accepted commands whose packets have not finished yet
  logic [DATA_WIDTH-1:0] base_q  [NUM_CHANNELS][$];
  len_t                  len_q   [NUM_CHANNELS][$];
  longint                stamp_q [NUM_CHANNELS][$]; // cycle of the command handshake

  longint                cycle;
  logic                  reset_checked;
  logic                  in_packet;
  chan_t                 cur_chan;
  int                    cur_idx;
  int                    pkt_errors;
  chan_t                 last_dest;
  logic                  prev_tvalid;
  logic                  stall_q;
  logic [DATA_WIDTH-1:0] stall_data;
  logic                  stall_last;
  chan_t                 stall_dest;

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("FAIL %s expected 0x%0h got 0x%0h at cycle %0d", name, expected, actual, cycle);
    error_count++;
    pkt_errors++;
  endtask

  task automatic report_problem(input string what);
    $display("ERROR %s at cycle %0d", what, cycle);
    error_count++;
    pkt_errors++;
  endtask

  ////////////////////////////////////////
  // per-edge comparison
  ////////////////////////////////////////

  always @(posedge M_AXIS_ACLK) begin
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_last;
    logic                  exp_ready;
    int                    want;
    int                    idx;
    if (!M_AXIS_ARESETN) begin
      cycle         = 0;
      error_count   = 0;
      packet_count  = 0;
      pending_count = 0;
      reset_checked = 1'b0;
      in_packet     = 1'b0;
      cur_idx       = 0;
      pkt_errors    = 0;
      last_dest     = chan_t'(NUM_CHANNELS - 1); // first scan starts at channel 0
      prev_tvalid   = 1'b0;
      stall_q       = 1'b0;
    end else begin
      cycle++;
      if (!reset_checked) begin
        if (tvalid !== 1'b0) report_mismatch("tvalid", 0, tvalid);
        if (cmd_ready !== 1'b1) report_mismatch("cmd_ready", 1, cmd_ready);
        $display("reset state checked");
        reset_checked = 1'b1;
      end

      // a channel is free exactly when nothing is outstanding on it
      exp_ready = int'(cmd_channel) < NUM_CHANNELS && base_q[cmd_channel].size() == 0;
      if (cmd_ready !== exp_ready) report_mismatch("cmd_ready", exp_ready, cmd_ready);

      if (stall_q) begin
        if (!tvalid) report_problem("tvalid dropped while the sink was stalling");
        if (tdata !== stall_data) report_mismatch("tdata", stall_data, tdata);
        if (tlast !== stall_last) report_mismatch("tlast", stall_last, tlast);
        if (tdest !== stall_dest) report_mismatch("tdest", stall_dest, tdest);
      end
      stall_q    = tvalid && !tready;
      stall_data = tdata;
      stall_last = tlast;
      stall_dest = tdest;

      // new grant: first channel after the last one whose generator was offering a word
      if (tvalid && !prev_tvalid) begin
        want = -1;
        for (int off = 1; off <= NUM_CHANNELS; off++) begin
          idx = (int'(last_dest) + off) % NUM_CHANNELS;
          if (want < 0 && base_q[idx].size() > 0 && stamp_q[idx][0] + START_COUNT + 2 <= cycle)
            want = idx;
        end
        if (want < 0) report_problem("output offered a packet with no channel ready to send");
        else if (tdest !== chan_t'(want)) report_mismatch("tdest", want, tdest);
        last_dest = tdest;
      end

      if (tvalid && tready) begin
        if (!in_packet) begin
          if (base_q[tdest].size() == 0) begin
            report_problem($sformatf("word on channel %0d with no command pending", tdest));
          end else begin
            in_packet  = 1'b1;
            cur_chan   = tdest;
            cur_idx    = 0;
            pkt_errors = 0;
          end
        end
        if (in_packet) begin
          exp_data = base_q[cur_chan][0] + DATA_WIDTH'(cur_idx + 1);
          exp_last = (cur_idx == int'(len_q[cur_chan][0]));
          if (tdest !== cur_chan) report_mismatch("tdest", cur_chan, tdest);
          if (tdata !== exp_data) report_mismatch("tdata", exp_data, tdata);
          if (tstrb !== '1) report_mismatch("tstrb", {(DATA_WIDTH/8){1'b1}}, tstrb);
          if (tlast !== exp_last) report_mismatch("tlast", exp_last, tlast);
          if (exp_last) begin
            $display("packet %0d channel %0d, %0d words: %s", packet_count, cur_chan,
                     cur_idx + 1, (pkt_errors == 0) ? "ok" : "mismatches found");
            void'(base_q[cur_chan].pop_front());
            void'(len_q[cur_chan].pop_front());
            void'(stamp_q[cur_chan].pop_front());
            packet_count++;
            pending_count--;
            in_packet = 1'b0;
          end else begin
            cur_idx++;
          end
        end
      end

      if (cmd_valid && cmd_ready) begin
        base_q[cmd_channel].push_back(cmd_base);
        len_q[cmd_channel].push_back(cmd_length);
        stamp_q[cmd_channel].push_back(cycle);
        pending_count++;
      end
      prev_tvalid = tvalid;
    end
  end

endmodule

// ==== verilog/stream_fabric_top.sv ====
module stream_fabric_top import axis_pkg::*; #(
  parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH,
  parameter int NUM_CHANNELS = DEFAULT_NUM_CHANNELS,
  parameter int START_COUNT  = DEFAULT_START_COUNT
) (
  input  logic                    M_AXIS_ACLK,
  input  logic                    M_AXIS_ARESETN,

  // command input
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  chan_t                   cmd_channel,
  input  len_t                    cmd_length,
  input  logic [DATA_WIDTH-1:0]   cmd_base,

  // merged stream output
  output logic                    tvalid,
  input  logic                    tready,
  output logic [DATA_WIDTH-1:0]   tdata,
  output logic [DATA_WIDTH/8-1:0] tstrb,
  output logic                    tlast,
  output chan_t                   tdest
);

  gen_cmd_if #(.DATA_WIDTH(DATA_WIDTH)) gen_cmd  [NUM_CHANNELS] ();
  axis_if    #(.DATA_WIDTH(DATA_WIDTH)) gen_axis [NUM_CHANNELS] ();

  ////////////////////////////////////////
  // command side
  ////////////////////////////////////////

  cmd_router #(
    .DATA_WIDTH   (DATA_WIDTH),
    .NUM_CHANNELS (NUM_CHANNELS)
  ) cmd_router_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .cmd_valid      (cmd_valid),
    .cmd_ready      (cmd_ready),
    .cmd_channel    (cmd_channel),
    .cmd_length     (cmd_length),
    .cmd_base       (cmd_base),
    .gen_cmd        (gen_cmd)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_gen
    packet_generator #(
      .DATA_WIDTH  (DATA_WIDTH),
      .START_COUNT (START_COUNT)
    ) packet_generator_inst (
      .M_AXIS_ACLK    (M_AXIS_ACLK),
      .M_AXIS_ARESETN (M_AXIS_ARESETN),
      .cmd            (gen_cmd[i]),
      .axis           (gen_axis[i])
    );
  end

  ////////////////////////////////////////
  // stream side
  ////////////////////////////////////////

  packet_arbiter #(
    .DATA_WIDTH   (DATA_WIDTH),
    .NUM_CHANNELS (NUM_CHANNELS)
  ) packet_arbiter_inst (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .src            (gen_axis),
    .tvalid         (tvalid),
    .tready         (tready),
    .tdata          (tdata),
    .tstrb          (tstrb),
    .tlast          (tlast),
    .tdest          (tdest)
  );

endmodule

// ==== verilog/packet_arbiter.sv ====
module packet_arbiter import axis_pkg::*, fabric_ctrl_pkg::*; #(
  parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH,
  parameter int NUM_CHANNELS = DEFAULT_NUM_CHANNELS
) (
  input  logic                    M_AXIS_ACLK,
  input  logic                    M_AXIS_ARESETN,
  axis_if.sink                    src [NUM_CHANNELS],
  output logic                    tvalid,
  input  logic                    tready,
  output logic [DATA_WIDTH-1:0]   tdata,
  output logic [DATA_WIDTH/8-1:0] tstrb,
  output logic                    tlast,
  output chan_t                   tdest
);

  arb_state_t              state;
  chan_t                   grant_q; // also the rotation point for the next scan
  chan_t                   pick;
  logic                    pick_found;
  logic [NUM_CHANNELS-1:0] src_tvalid;
  logic [NUM_CHANNELS-1:0] src_tlast;
  logic [DATA_WIDTH-1:0]   src_tdata [NUM_CHANNELS];
  logic [DATA_WIDTH/8-1:0] src_tstrb [NUM_CHANNELS];

  ////////////////////////////////////////
  // gather the source links
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_src
    assign src_tvalid[i] = src[i].tvalid;
    assign src_tlast[i]  = src[i].tlast;
    assign src_tdata[i]  = src[i].tdata;
    assign src_tstrb[i]  = src[i].tstrb;
    assign src[i].tready = tready && (state == ARB_HOLD) && (grant_q == chan_t'(i));
  end

  // rotating priority, starting one past the last grant
  always_comb begin
    int idx;
    pick       = grant_q;
    pick_found = 1'b0;
    for (int off = 1; off <= NUM_CHANNELS; off++) begin
      idx = (int'(grant_q) + off) % NUM_CHANNELS;
      if (!pick_found && src_tvalid[idx]) begin
        pick       = chan_t'(idx);
        pick_found = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // grant FSM
  ////////////////////////////////////////

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state   <= ARB_SCAN;
      grant_q <= chan_t'(NUM_CHANNELS - 1); // channel 0 wins the first scan
    end else begin
      case (state)
        ARB_SCAN: begin
          if (pick_found) begin
            state   <= ARB_HOLD;
            grant_q <= pick;
          end
        end
        ARB_HOLD: begin
          if (tvalid && tready && tlast) begin
            state <= ARB_SCAN;
          end
        end
        default: state <= ARB_SCAN;
      endcase
    end
  end

  assign tvalid = (state == ARB_HOLD) && src_tvalid[grant_q];
  assign tdata  = src_tdata[grant_q];
  assign tstrb  = src_tstrb[grant_q];
  assign tlast  = src_tlast[grant_q];
  assign tdest  = grant_q;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // a granted packet keeps the output, offered, until its tlast goes through
  a_grant_hold : assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    state == ARB_HOLD && !(tvalid && tready && tlast) |=>
      state == ARB_HOLD && $stable(grant_q) && tvalid
  );

endmodule

// ==== verilog/packet_generator.sv ====
module packet_generator import axis_pkg::*, fabric_ctrl_pkg::*; #(
  parameter int DATA_WIDTH  = DEFAULT_DATA_WIDTH,
  parameter int START_COUNT = DEFAULT_START_COUNT
) (
  input  logic   M_AXIS_ACLK,
  input  logic   M_AXIS_ARESETN,
  gen_cmd_if.gen cmd,
  axis_if.source axis
);

  localparam int WAIT_W = $clog2(START_COUNT + 1);

  gen_state_t            state;
  logic [WAIT_W-1:0]     wait_cnt;
  len_t                  word_cnt;
  len_t                  length_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic                  cmd_take;
  logic                  word_take;
  logic                  wait_done;

  assign cmd_take  = cmd.valid && cmd.ready;
  assign word_take = axis.tvalid && axis.tready;
  assign wait_done = (wait_cnt == WAIT_W'(START_COUNT - 1));

  ////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state    <= GEN_IDLE;
      wait_cnt <= '0;
      word_cnt <= '0;
    end else begin
      case (state)
        GEN_IDLE: begin
          if (cmd_take) begin
            state    <= GEN_WAIT;
            wait_cnt <= '0;
            word_cnt <= '0;
          end
        end
        GEN_WAIT: begin
          if (wait_done) begin
            state <= GEN_SEND; // tvalid comes up with this edge
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        GEN_SEND: begin
          if (word_take) begin
            if (axis.tlast) begin
              state <= GEN_IDLE;
            end else begin
              word_cnt <= word_cnt + 1'b1;
            end
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge M_AXIS_ACLK) begin
    if (cmd_take) begin
      length_q <= cmd.length;
      data_q   <= cmd.base + DATA_WIDTH'(1); // first word is base plus one
    end else if (word_take) begin
      data_q <= data_q + DATA_WIDTH'(1);
    end
  end

  assign cmd.ready   = (state == GEN_IDLE);
  assign axis.tvalid = (state == GEN_SEND);
  assign axis.tdata  = data_q;
  assign axis.tstrb  = '1;
  assign axis.tlast  = (word_cnt == length_q);

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // a stalled word stays offered and unchanged until the arbiter takes it
  a_tvalid_hold : assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    axis.tvalid && !axis.tready |=>
      axis.tvalid && $stable(axis.tdata) && $stable(axis.tlast)
  );

  // an accepted command blocks the channel through the whole start delay
  a_busy_after_cmd : assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    cmd_take |=> (state == GEN_WAIT && !cmd.ready) [*START_COUNT]
      ##1 (state == GEN_SEND && !cmd.ready)
  );

endmodule

// ==== verilog/cmd_router.sv ====
module cmd_router import axis_pkg::*; #(
  parameter int DATA_WIDTH   = DEFAULT_DATA_WIDTH,
  parameter int NUM_CHANNELS = DEFAULT_NUM_CHANNELS
) (
  input  logic                  M_AXIS_ACLK,
  input  logic                  M_AXIS_ARESETN,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  chan_t                 cmd_channel,
  input  len_t                  cmd_length,
  input  logic [DATA_WIDTH-1:0] cmd_base,
  gen_cmd_if.router             gen_cmd [NUM_CHANNELS]
);

  logic [NUM_CHANNELS-1:0] ready_vec;

  ////////////////////////////////////////
  // per-channel fan-out
  ////////////////////////////////////////

  for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
    assign gen_cmd[i].valid  = cmd_valid && (cmd_channel == chan_t'(i)); // one-hot decode
    assign gen_cmd[i].length = cmd_length;
    assign gen_cmd[i].base   = cmd_base;
    assign ready_vec[i]      = gen_cmd[i].ready;
  end

  // a channel number past the last generator is never accepted
  assign cmd_ready = (int'(cmd_channel) < NUM_CHANNELS) && ready_vec[cmd_channel];

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // the upstream source must hold a stalled command until a generator takes it
  a_cmd_hold : assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    cmd_valid && !cmd_ready |=>
      cmd_valid && $stable(cmd_channel) && $stable(cmd_length) && $stable(cmd_base)
  );

endmodule

// ==== verilog/fabric_if.sv ====
// one AXI4-Stream link from a generator to the arbiter
interface axis_if import axis_pkg::*; #(
  parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
);

  logic                    tvalid;
  logic                    tready;
  logic [DATA_WIDTH-1:0]   tdata;
  logic [DATA_WIDTH/8-1:0] tstrb;
  logic                    tlast;

  modport source (
    output tvalid, tdata, tstrb, tlast,
    input  tready
  );

  modport sink (
    input  tvalid, tdata, tstrb, tlast,
    output tready
  );

endinterface

// one command link from the router to a generator
interface gen_cmd_if import axis_pkg::*; #(
  parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
);

  logic                  valid;
  logic                  ready;
  len_t                  length;
  logic [DATA_WIDTH-1:0] base;

  modport router (output valid, length, base, input ready);

  modport gen (input valid, length, base, output ready);

endinterface

// ==== verilog/fabric_ctrl_pkg.sv ====
package fabric_ctrl_pkg;

  // packet generator FSM
  typedef enum logic [1:0] {
    GEN_IDLE = 2'b00, // waiting for a command
    GEN_WAIT = 2'b01, // start delay running
    GEN_SEND = 2'b10  // packet words on the stream
  } gen_state_t;

  // packet arbiter FSM
  typedef enum logic {
    ARB_SCAN = 1'b0, // looking for the next source
    ARB_HOLD = 1'b1  // granted source owns the output until tlast
  } arb_state_t;

endpackage

// ==== verilog/axis_pkg.sv ====
package axis_pkg;

  ////////////////////////////////////////
  // stream-side defaults
  ////////////////////////////////////////

  localparam int DEFAULT_DATA_WIDTH   = 32;
  localparam int DEFAULT_NUM_CHANNELS = 4;
  localparam int DEFAULT_START_COUNT  = 8; // idle cycles before each packet

  ////////////////////////////////////////
  // command field types
  ////////////////////////////////////////

  // packet length minus one, so 1 to 256 words
  typedef logic [7:0] len_t;

  // two bits limit the fabric to four channels
  typedef logic [1:0] chan_t;

endpackage
